//--- rtl/risc8_pkg.sv
`default_nettype none

package risc8_pkg;

	// basic data widths
	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [4:0] reg_sel_t;

	// low byte of each pointer pair
	localparam reg_sel_t PTR_X = 5'd26;
	localparam reg_sel_t PTR_Y = 5'd28;
	localparam reg_sel_t PTR_Z = 5'd30;

	// status register bit positions
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_V = 3;
	localparam int FLAG_S = 4;
	localparam int FLAG_H = 5;

	// alu operations, carry-in is selected separately
	typedef enum logic [2:0] {
		MOVE,
		MOVR,
		ADD,
		SUB,
		AND,
		OR,
		EOR
	} alu_op_e;

	// instruction classes seen by the sequencer
	typedef enum logic [2:0] {
		ALU,
		RJMP,
		BRANCH,
		LD_PTR,
		ST_PTR,
		INVALID
	} instr_e;

	typedef struct packed {
		instr_e instr;
		alu_op_e op;
		logic use_carry;
		logic store_result;
		logic use_const;
		byte_t const_val;
		reg_sel_t sel_a;
		reg_sel_t sel_b;
		reg_sel_t sel_d;
		logic [2:0] bit_idx;
		// set for BRBC, clear for BRBS
		logic br_clear;
		word_t offset;
	} decoded_t;

	// latched at the end of stage one for the alu in stage two
	typedef struct packed {
		alu_op_e op;
		logic use_carry;
		logic store_result;
		logic use_const;
		byte_t const_val;
		reg_sel_t dest;
	} exec_t;

	typedef enum logic [1:0] {
		CYC_FIRST,
		CYC_ACCESS,
		CYC_LOAD
	} cyc_e;

endpackage

`default_nettype wire

//--- rtl/risc8_decode.sv
`timescale 1ns/1ps
`default_nettype none

module risc8_decode import risc8_pkg::*; (
	input wire word_t opcode,
	output decoded_t dec
);
	// operand fields of the opcode
	reg_sel_t op_rd;
	reg_sel_t op_rr;
	reg_sel_t op_rdi;
	reg_sel_t op_ptr;
	byte_t op_k;

	assign op_rd = opcode[8:4];
	assign op_rr = {opcode[9], opcode[3:0]};
	// immediate forms only reach r16 to r31
	assign op_rdi = {1'b1, opcode[7:4]};
	assign op_k = {opcode[11:8], opcode[3:0]};
	// 11 is X, 10 is Y, 00 is Z
	assign op_ptr = (opcode[3:2] == 2'b11) ? PTR_X : (opcode[3] ? PTR_Y : PTR_Z);

	// register-register alu group
	alu_op_e r_op;
	logic r_ok;
	logic r_carry;
	logic r_store;

	always_comb begin
		r_ok = 1'b1;
		r_carry = 1'b0;
		r_store = 1'b1;
		r_op = MOVE;
		case (opcode[15:10])
			6'b000011: r_op = ADD;
			6'b000111: begin
				// ADC
				r_op = ADD;
				r_carry = 1'b1;
			end
			6'b000110: r_op = SUB;
			6'b000010: begin
				// SBC
				r_op = SUB;
				r_carry = 1'b1;
			end
			6'b000101: begin
				// CP, flags only
				r_op = SUB;
				r_store = 1'b0;
			end
			6'b001000: r_op = AND;
			6'b001001: r_op = EOR;
			6'b001010: r_op = OR;
			6'b001011: r_op = MOVR;
			default: r_ok = 1'b0;
		endcase
	end

	// register-immediate alu group
	alu_op_e i_op;
	logic i_ok;
	logic i_carry;
	logic i_store;

	always_comb begin
		i_ok = 1'b1;
		i_carry = 1'b0;
		i_store = 1'b1;
		i_op = MOVE;
		case (opcode[15:12])
			4'b0011: begin
				// CPI
				i_op = SUB;
				i_store = 1'b0;
			end
			4'b0100: begin
				// SBCI
				i_op = SUB;
				i_carry = 1'b1;
			end
			4'b0101: i_op = SUB;
			4'b0110: i_op = OR;
			4'b0111: i_op = AND;
			// LDI just moves K into Rd
			4'b1110: i_op = MOVR;
			default: i_ok = 1'b0;
		endcase
	end

	always_comb begin
		// anything unmatched stays INVALID with no writeback
		dec = '0;
		dec.instr = INVALID;
		dec.op = MOVE;
		dec.sel_a = op_rd;
		dec.sel_b = op_rr;
		dec.sel_d = op_rd;
		dec.bit_idx = opcode[2:0];
		dec.br_clear = opcode[10];

		if (r_ok) begin
			dec.instr = ALU;
			dec.op = r_op;
			dec.use_carry = r_carry;
			dec.store_result = r_store;
		end else if (i_ok) begin
			dec.instr = ALU;
			dec.op = i_op;
			dec.use_carry = i_carry;
			dec.store_result = i_store;
			dec.use_const = 1'b1;
			dec.const_val = op_k;
			dec.sel_a = op_rdi;
			dec.sel_d = op_rdi;
		end else begin
			casez (opcode)
				16'b1100_????_????_????: begin
					dec.instr = RJMP;
					dec.offset = {{4{opcode[11]}}, opcode[11:0]};
				end
				16'b1111_0???_????_????: begin
					// BRBS / BRBC, 7 bit signed offset
					dec.instr = BRANCH;
					dec.offset = {{9{opcode[9]}}, opcode[9:3]};
				end
				16'b1001_000?_????_1100,
				16'b1000_000?_????_?000: begin
					dec.instr = LD_PTR;
					dec.sel_a = op_ptr;
				end
				16'b1001_001?_????_1100,
				16'b1000_001?_????_?000: begin
					// Rr sits in the Rd field for stores
					dec.instr = ST_PTR;
					dec.sel_a = op_ptr;
					dec.sel_b = op_rd;
				end
				default: dec.instr = INVALID;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/risc8_regs.sv
`timescale 1ns/1ps
`default_nettype none

module risc8_regs import risc8_pkg::*; (
	input wire clk,
	input wire reset,
	input wire reg_sel_t sel_a,
	input wire reg_sel_t sel_b,
	output word_t reg_a,
	output byte_t reg_b,
	input wire reg_sel_t sel_d,
	input wire byte_t wdata,
	input wire write
);
	byte_t regs [32];

	// upper byte of the pair, wraps from r31 to r0
	reg_sel_t sel_a_hi;
	assign sel_a_hi = sel_a + 5'd1;

	// write port
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write) begin
			regs[sel_d] <= wdata;
		end
	end

	// registered reads, a write landing on the same edge is forwarded
	always_ff @(posedge clk) begin
		if (write && sel_d == sel_a)
			reg_a[7:0] <= wdata;
		else
			reg_a[7:0] <= regs[sel_a];

		if (write && sel_d == sel_a_hi)
			reg_a[15:8] <= wdata;
		else
			reg_a[15:8] <= regs[sel_a_hi];

		if (write && sel_d == sel_b)
			reg_b <= wdata;
		else
			reg_b <= regs[sel_b];
	end

endmodule

`default_nettype wire

//--- rtl/risc8_alu.sv
`timescale 1ns/1ps
`default_nettype none

module risc8_alu import risc8_pkg::*; (
	input wire exec_t ex,
	input wire word_t rd_in,
	input wire byte_t rr_in,
	input wire byte_t sreg_in,
	output word_t alu_out,
	output byte_t sreg_next
);
	byte_t op_a;
	byte_t op_b;
	byte_t res;
	logic [8:0] sum;
	logic carry_in;
	logic half;
	logic ovf;
	// arithmetic ops touch C and H as well
	logic is_arith;
	logic flags_upd;

	assign op_a = rd_in[7:0];
	// immediates and load data arrive through the constant
	assign op_b = ex.use_const ? ex.const_val : rr_in;
	assign carry_in = ex.use_carry & sreg_in[FLAG_C];

	always_comb begin
		sum = '0;
		half = 1'b0;
		ovf = 1'b0;
		is_arith = 1'b0;
		flags_upd = 1'b1;
		res = op_a;
		case (ex.op)
			MOVE: flags_upd = 1'b0;
			MOVR: begin
				res = op_b;
				flags_upd = 1'b0;
			end
			ADD: begin
				sum = {1'b0, op_a} + {1'b0, op_b} + {8'h00, carry_in};
				res = sum[7:0];
				is_arith = 1'b1;
				half = (op_a[3] & op_b[3]) | (op_b[3] & ~res[3]) | (~res[3] & op_a[3]);
				ovf = (op_a[7] & op_b[7] & ~res[7]) | (~op_a[7] & ~op_b[7] & res[7]);
			end
			SUB: begin
				// sum[8] ends up as the borrow
				sum = {1'b0, op_a} - {1'b0, op_b} - {8'h00, carry_in};
				res = sum[7:0];
				is_arith = 1'b1;
				half = (~op_a[3] & op_b[3]) | (op_b[3] & res[3]) | (res[3] & ~op_a[3]);
				ovf = (op_a[7] & ~op_b[7] & ~res[7]) | (~op_a[7] & op_b[7] & res[7]);
			end
			AND: res = op_a & op_b;
			OR: res = op_a | op_b;
			EOR: res = op_a ^ op_b;
			default: flags_upd = 1'b0;
		endcase
	end

	// high byte passes through so MOVE hands on a whole pair
	assign alu_out = {rd_in[15:8], res};

	always_comb begin
		sreg_next = sreg_in;
		if (flags_upd) begin
			if (is_arith) begin
				sreg_next[FLAG_C] = sum[8];
				sreg_next[FLAG_H] = half;
			end
			// logic ops clear V
			sreg_next[FLAG_V] = ovf;
			sreg_next[FLAG_N] = res[7];
			sreg_next[FLAG_S] = res[7] ^ ovf;
			// carry chains only keep Z if the lower bytes were zero too
			sreg_next[FLAG_Z] = (res == 8'h00) & (~ex.use_carry | sreg_in[FLAG_Z]);
		end
	end

endmodule

`default_nettype wire

//--- rtl/risc8_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module risc8_sequencer import risc8_pkg::*; (
	input wire clk,
	input wire reset,
	input wire word_t cdata,
	input wire decoded_t dec,
	output word_t opcode,
	input wire word_t reg_a,
	input wire byte_t reg_b,
	input wire byte_t sreg_next,
	output byte_t sreg,
	output reg_sel_t sel_a,
	output reg_sel_t sel_b,
	output exec_t ex,
	output reg_sel_t wr_sel,
	output logic wr_en,
	output word_t pc,
	output word_t data_addr,
	output logic data_wen,
	output logic data_ren,
	output byte_t data_write,
	input wire byte_t data_read
);
	// pc_q is the address of the word now on cdata
	word_t pc_q;
	word_t next_pc;
	cyc_e cyc;
	cyc_e next_cyc;
	word_t prev_opcode;
	byte_t sreg_q;
	exec_t ex_q;
	exec_t ex_d;

	// multi-cycle instructions keep decoding the same opcode
	assign opcode = (cyc == CYC_FIRST) ? cdata : prev_opcode;

	// fetch address for the following cycle
	assign pc = reset ? '0 : next_pc;

	assign sreg = sreg_q;
	assign ex = ex_q;
	// stage two writes back what stage one latched
	assign wr_sel = ex_q.dest;
	assign wr_en = ex_q.store_result;

	always_comb begin
		next_pc = pc_q + 16'd1;
		next_cyc = CYC_FIRST;
		data_addr = '0;
		data_wen = 1'b0;
		data_ren = 1'b0;
		data_write = '0;

		sel_a = dec.sel_a;
		sel_b = dec.sel_b;

		ex_d.op = dec.op;
		ex_d.use_carry = dec.use_carry;
		ex_d.store_result = dec.store_result;
		ex_d.use_const = dec.use_const;
		ex_d.const_val = dec.const_val;
		ex_d.dest = dec.sel_d;

		case (dec.instr)
			RJMP: next_pc = pc_q + dec.offset + 16'd1;
			BRANCH: begin
				// flags of the instruction still in the alu
				if (sreg_next[dec.bit_idx] != dec.br_clear)
					next_pc = pc_q + dec.offset + 16'd1;
			end
			ST_PTR: begin
				if (cyc == CYC_FIRST) begin
					// wait for the pointer pair and Rr
					next_cyc = CYC_ACCESS;
				end else begin
					data_wen = 1'b1;
					data_addr = reg_a;
					data_write = reg_b;
				end
			end
			LD_PTR: begin
				case (cyc)
					CYC_FIRST: next_cyc = CYC_ACCESS;
					CYC_ACCESS: begin
						data_ren = 1'b1;
						data_addr = reg_a;
						next_cyc = CYC_LOAD;
					end
					default: begin
						// read data goes into Rd through the alu
						ex_d.op = MOVR;
						ex_d.store_result = 1'b1;
						ex_d.use_const = 1'b1;
						ex_d.const_val = data_read;
					end
				endcase
			end
			default: begin
				// alu and invalid opcodes take the decoder fields as they are
				next_cyc = CYC_FIRST;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		prev_opcode <= opcode;
		if (reset) begin
			pc_q <= '0;
			cyc <= CYC_FIRST;
			sreg_q <= '0;
			ex_q <= '0;
		end else begin
			// pc holds until the last cycle of the instruction
			if (next_cyc == CYC_FIRST)
				pc_q <= next_pc;
			cyc <= next_cyc;
			sreg_q <= sreg_next;
			ex_q <= ex_d;
		end
	end

endmodule

`default_nettype wire

//--- rtl/risc8_core.sv
`timescale 1ns/1ps
`default_nettype none

module risc8_core import risc8_pkg::*; (
	input wire clk,
	input wire reset,
	// synchronous program memory, one word per cycle
	output word_t pc,
	input wire word_t cdata,
	// data memory
	output word_t data_addr,
	output logic data_wen,
	output logic data_ren,
	output byte_t data_write,
	input wire byte_t data_read
);
	word_t opcode;
	decoded_t dec;
	reg_sel_t sel_a;
	reg_sel_t sel_b;
	word_t reg_a;
	byte_t reg_b;
	exec_t ex;
	reg_sel_t wr_sel;
	logic wr_en;
	word_t alu_out;
	byte_t sreg;
	byte_t sreg_next;

	risc8_decode decode_i (
		.opcode(opcode),
		.dec(dec)
	);

	risc8_sequencer seq_i (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.dec(dec),
		.opcode(opcode),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.sreg_next(sreg_next),
		.sreg(sreg),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.ex(ex),
		.wr_sel(wr_sel),
		.wr_en(wr_en),
		.pc(pc),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_write(data_write),
		.data_read(data_read)
	);

	// writeback takes the low byte of the alu result
	risc8_regs regs_i (
		.clk(clk),
		.reset(reset),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.sel_d(wr_sel),
		.wdata(alu_out[7:0]),
		.write(wr_en)
	);

	risc8_alu alu_i (
		.ex(ex),
		.rd_in(reg_a),
		.rr_in(reg_b),
		.sreg_in(sreg),
		.alu_out(alu_out),
		.sreg_next(sreg_next)
	);

endmodule

`default_nettype wire

//--- verif/risc8_checker.sv
`timescale 1ns/1ps
`default_nettype none

module risc8_checker import risc8_pkg::*; (
	input wire clk,
	input wire reset,
	input wire word_t pc,
	input wire word_t data_addr,
	input wire data_wen,
	input wire data_ren,
	input wire byte_t data_write,
	output int pass_count,
	output int fail_count
);
	// expected stores, oldest first
	word_t exp_addr [$];
	byte_t exp_data [$];
	int test_num;
	logic reset_seen;
	logic reset_bad;
	logic store_ok;
	word_t want_addr;
	byte_t want_data;

	initial begin
		pass_count = 0;
		fail_count = 0;
		test_num = 0;
		reset_seen = 1'b0;
		reset_bad = 1'b0;
	end

	task automatic expect_store(input word_t addr, input byte_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// whatever is left in the queue never reached the bus
	task automatic finish_checks(output int missing);
		missing = exp_addr.size();
		if (missing > 0)
			$display("%0d expected stores never happened before the program ended", missing);
	endtask

	// outputs are settled mid cycle
	always @(negedge clk) begin
		if (reset === 1'b1) begin
			// no bus traffic and fetch held at 0 while in reset
			if (data_wen !== 1'b0 || data_ren !== 1'b0) begin
				$display("a data strobe was raised while reset was high at %0t", $time);
				reset_bad = 1'b1;
			end
			if (pc !== 16'h0000) begin
				$display("FAILED pc during reset: expected %h, got %h", 16'h0000, pc);
				reset_bad = 1'b1;
			end
		end else if (!reset_seen) begin
			reset_seen = 1'b1;
			if (reset_bad) begin
				$display("test 0 reset: failed");
				fail_count++;
			end else begin
				$display("test 0 reset: passed");
				pass_count++;
			end
		end

		if (reset === 1'b0 && data_wen === 1'b1) begin
			test_num++;
			if (exp_addr.size() == 0) begin
				$display("test %0d: store of %h to %h came after all expected stores",
					test_num, data_write, data_addr);
				fail_count++;
			end else begin
				store_ok = 1'b1;
				want_addr = exp_addr.pop_front();
				want_data = exp_data.pop_front();
				if (data_addr !== want_addr) begin
					$display("FAILED data_addr in test %0d: expected %h, got %h",
						test_num, want_addr, data_addr);
					store_ok = 1'b0;
				end
				if (data_write !== want_data) begin
					$display("FAILED data_write in test %0d: expected %h, got %h",
						test_num, want_data, data_write);
					store_ok = 1'b0;
				end
				if (store_ok) begin
					$display("test %0d store: passed, %h written to %h",
						test_num, data_write, data_addr);
					pass_count++;
				end else begin
					$display("test %0d store: failed", test_num);
					fail_count++;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/risc8_tb.sv
`timescale 1ns/1ps
`default_nettype none

module risc8_tb import risc8_pkg::*; ();
	localparam int MEM_WORDS = 256;
	// marks the end of the program and of the store list
	localparam logic [31:0] SEPARATOR = 32'hffffffff;

	logic clk;
	logic reset;
	word_t pc;
	word_t cdata;
	word_t data_addr;
	logic data_wen;
	logic data_ren;
	byte_t data_write;
	byte_t data_read;

	logic [31:0] vectors [MEM_WORDS];
	word_t rom [MEM_WORDS];
	byte_t ram [MEM_WORDS];
	int prog_words;
	int pass_count;
	int fail_count;
	int missing;

	risc8_core dut_i (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_write(data_write),
		.data_read(data_read)
	);

	risc8_checker chk_i (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_write(data_write),
		.pass_count(pass_count),
		.fail_count(fail_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// synchronous program rom and data ram, one cycle latency each
	always @(posedge clk) begin
		cdata <= rom[pc[7:0]];
		if (data_wen)
			ram[data_addr[7:0]] <= data_write;
		if (data_ren)
			data_read <= ram[data_addr[7:0]];
	end

	task automatic load_vectors();
		int i;
		for (i = 0; i < MEM_WORDS; i++) begin
			vectors[i] = SEPARATOR;
			// unused rom reads as an invalid opcode, so a nop
			rom[i] = '0;
			ram[i] = byte_t'(i) ^ 8'h5a;
		end
		$readmemh("verif/risc8_vectors.txt", vectors);
		i = 0;
		while (i < MEM_WORDS && vectors[i] != SEPARATOR) begin
			rom[i] = vectors[i][15:0];
			i++;
		end
		prog_words = i;
		// store records follow the separator
		i++;
		while (i < MEM_WORDS && vectors[i] != SEPARATOR) begin
			chk_i.expect_store(vectors[i][31:16], vectors[i][7:0]);
			i++;
		end
	endtask

	// worst case 3 cycles per word, forward branches only
	initial begin
		wait (prog_words > 0 && reset === 1'b0);
		#(prog_words * 3 * 8 + 200);
		$display("timeout: the program did not reach its last word in time");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		cdata = '0;
		data_read = '0;
		prog_words = 0;
		missing = 0;
		load_vectors();
		if (prog_words == 0) begin
			$display("the vector file holds no program words");
			$display("TEST FAILED");
			$finish;
		end else begin
			repeat (10) @(posedge clk);
			reset <= 1'b0;
			@(negedge clk);
			// last word is a jump to itself
			while (pc !== word_t'(prog_words - 1))
				@(negedge clk);
			// drain the final store
			repeat (4) @(negedge clk);
			chk_i.finish_checks(missing);
			$display("tests passed: %0d, tests failed: %0d, stores missing: %0d",
				pass_count, fail_count, missing);
			if (fail_count == 0 && missing == 0)
				$display("TEST PASSED");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verif/risc8_vectors.txt
// program words first, one opcode per line, then the separator ffffffff
// after it the expected stores in order: bits 31:16 address, bits 7:0 data
e4a0 // ldi r26, 0x40
e5c0 // ldi r28, 0x50
e6e0 // ldi r30, 0x60
e30c // ldi r16, 0x3c
e219 // ldi r17, 0x29
0f01 // add r16, r17
930c // st x, r16
541a // subi r17, 0x4a
2701 // eor r16, r17
8308 // st y, r16
6210 // ori r17, 0x20
751c // andi r17, 0x5c
2f21 // mov r18, r17
8320 // st z, r18
ef40 // ldi r20, 0xf0
e152 // ldi r21, 0x12
e365 // ldi r22, 0x35
e071 // ldi r23, 0x01
0f46 // add r20, r22
1f57 // adc r21, r23
e4a1 // ldi r26, 0x41
935c // st x, r21
8348 // st y, r20
e080 // ldi r24, 0x00
e091 // ldi r25, 0x01
1b87 // sub r24, r23
0992 // sbc r25, r2
f009 // brbs 1, +1 (z stays clear through the sbc chain)
8390 // st z, r25
938c // st x, r24
351c // cpi r17, 0x5c
f009 // brbs 1, +1 (taken)
931c // st x, r17 (skipped)
1702 // cp r16, r18
f408 // brbc 0, +1 (taken)
930c // st x, r16 (skipped)
3620 // cpi r18, 0x60
f408 // brbc 0, +1 (not taken)
8328 // st y, r18
c001 // rjmp +1
8318 // st y, r17 (skipped)
e9ec // ldi r30, 0x9c
8130 // ld r19, z
8338 // st y, r19
9508 // invalid opcode
930c // st x, r16
cfff // rjmp -1, end of program
ffffffff
00400065
005000ba
0060005c
00410014
00500025
00600000
004100ff
0050005c
005000c6
004100ba

//--- vlog.f
rtl/risc8_pkg.sv
rtl/risc8_decode.sv
rtl/risc8_regs.sv
rtl/risc8_alu.sv
rtl/risc8_sequencer.sv
rtl/risc8_core.sv
verif/risc8_checker.sv
verif/risc8_tb.sv
